// ==== source/pipePkg.sv ====
package pipePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [29:0] wordAddr_t;   // cache ports address words
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  fwdSel_t;

    localparam int NUM_REGS = 32;

    // ALU select values
    localparam aluOp_t ALU_AND = 4'd0;
    localparam aluOp_t ALU_OR  = 4'd1;
    localparam aluOp_t ALU_ADD = 4'd2;
    localparam aluOp_t ALU_SLL = 4'd3;
    localparam aluOp_t ALU_SRL = 4'd4;
    localparam aluOp_t ALU_SRA = 4'd5;
    localparam aluOp_t ALU_SUB = 4'd6;
    localparam aluOp_t ALU_SLT = 4'd7;
    localparam aluOp_t ALU_XOR = 4'd8;

    // major opcode in instr[6:2]
    localparam logic [4:0] OP_REG   = 5'b01100;
    localparam logic [4:0] OP_IMM   = 5'b00100;
    localparam logic [4:0] OP_LOAD  = 5'b00000;
    localparam logic [4:0] OP_STORE = 5'b01000;

    // instruction class seen by the ALU control
    localparam logic [1:0] CLS_MEM = 2'b00;   // lw/sw address add
    localparam logic [1:0] CLS_REG = 2'b01;
    localparam logic [1:0] CLS_IMM = 2'b10;

    // operand source in EX
    localparam fwdSel_t FWD_NONE = 2'b00;
    localparam fwdSel_t FWD_WB   = 2'b01;
    localparam fwdSel_t FWD_MEM  = 2'b10;

endpackage

// ==== source/instrDecoder.sv ====
module instrDecoder import pipePkg::*; (
    input  word_t      instr,
    output logic       regWrite,
    output logic       memRead,
    output logic       memWrite,
    output logic       memToReg,
    output logic       aluSrc,
    output logic [1:0] aluClass,
    output word_t      imm,
    output regAddr_t   rs1,
    output regAddr_t   rs2,
    output regAddr_t   rd
);

    logic [4:0] opcode;
    logic       isWide;   // low bits 11 mean a full 32-bit encoding

    assign opcode = instr[6:2];
    assign isWide = (instr[1:0] == 2'b11);

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        aluClass = CLS_MEM;
        imm      = '0;

        if (isWide) begin
            case (opcode)
                OP_REG: begin
                    regWrite = 1'b1;
                    aluClass = CLS_REG;
                end
                OP_IMM: begin
                    regWrite = 1'b1;
                    aluSrc   = 1'b1;
                    aluClass = CLS_IMM;
                    imm      = {{20{instr[31]}}, instr[31:20]};
                end
                OP_LOAD: begin
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    aluSrc   = 1'b1;
                    imm      = {{20{instr[31]}}, instr[31:20]};
                end
                OP_STORE: begin
                    memWrite = 1'b1;
                    aluSrc   = 1'b1;
                    // S-type splits the offset around rd
                    imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
                default: begin
                    regWrite = 1'b0;   // unknown opcode acts as nop
                end
            endcase
        end
    end

endmodule

// ==== source/execUnit.sv ====
module execUnit import pipePkg::*; (
    input  logic [1:0] aluClass,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       aluSrc,
    input  word_t      rData1,
    input  word_t      rData2,
    input  word_t      imm,
    input  word_t      memResult,
    input  word_t      wbResult,
    input  fwdSel_t    fwdSelA,
    input  fwdSel_t    fwdSelB,
    output word_t      aluResult,
    output word_t      storeData
);

    aluOp_t aluOp;
    word_t  opA;
    word_t  opB;

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal,
                                     word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA       = fwdMux(fwdSelA, rData1, memResult, wbResult);
    assign storeData = fwdMux(fwdSelB, rData2, memResult, wbResult);
    assign opB       = aluSrc ? imm : storeData;

    // ALU control
    always_comb begin
        aluOp = ALU_ADD;   // lw/sw address
        if (aluClass != CLS_MEM) begin
            case (funct3)
                3'b000: begin
                    // addi never subtracts
                    aluOp = (aluClass == CLS_REG && funct7b5) ? ALU_SUB : ALU_ADD;
                end
                3'b001: aluOp = ALU_SLL;
                3'b010: aluOp = ALU_SLT;
                3'b100: aluOp = ALU_XOR;
                3'b101: aluOp = funct7b5 ? ALU_SRA : ALU_SRL;
                3'b110: aluOp = ALU_OR;
                3'b111: aluOp = ALU_AND;
                default: aluOp = ALU_ADD;   // sltu not implemented
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            ALU_ADD: aluResult = opA + opB;
            ALU_SUB: aluResult = opA - opB;
            ALU_XOR: aluResult = opA ^ opB;
            ALU_SLL: aluResult = opA << opB[4:0];
            ALU_SRL: aluResult = opA >> opB[4:0];
            ALU_SRA: aluResult = $signed(opA) >>> opB[4:0];
            ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

endmodule

// ==== source/regFile.sv ====
module regFile import pipePkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    output word_t    rData1,
    output word_t    rData2,
    input  logic     we,
    input  regAddr_t rd,
    input  word_t    wData
);

    word_t regs [NUM_REGS];

    // x0 check first so a write to x0 is never bypassed
    assign rData1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wData : regs[rs1];
    assign rData2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wData : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wData;
        end
    end

endmodule

// ==== source/hazardUnit.sv ====
module hazardUnit import pipePkg::*; (
    input  regAddr_t idRs1,
    input  regAddr_t idRs2,
    input  regAddr_t exRs1,
    input  regAddr_t exRs2,
    input  regAddr_t exRd,
    input  regAddr_t memRd,
    input  regAddr_t wbRd,
    input  logic     exMemRead,
    input  logic     memRegWrite,
    input  logic     wbRegWrite,
    output fwdSel_t  fwdSelA,
    output fwdSel_t  fwdSelB,
    output logic     loadUseStall
);

    function automatic logic hit(logic wr, regAddr_t dst, regAddr_t src);
        return wr && (dst != '0) && (dst == src);
    endfunction

    // younger result in EX/MEM wins
    assign fwdSelA = hit(memRegWrite, memRd, exRs1) ? FWD_MEM :
                     hit(wbRegWrite, wbRd, exRs1)   ? FWD_WB  : FWD_NONE;
    assign fwdSelB = hit(memRegWrite, memRd, exRs2) ? FWD_MEM :
                     hit(wbRegWrite, wbRd, exRs2)   ? FWD_WB  : FWD_NONE;

    // load data only exists after MEM so one bubble covers it
    assign loadUseStall = hit(exMemRead, exRd, idRs1) || hit(exMemRead, exRd, idRs2);

endmodule

// ==== source/riscvPipeline.sv ====
module riscvPipeline import pipePkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    output wordAddr_t icacheAddr,
    input  word_t     icacheRdata,
    input  logic      icacheStall,
    output logic      dcacheRen,
    output logic      dcacheWen,
    output wordAddr_t dcacheAddr,
    output word_t     dcacheWdata,
    input  word_t     dcacheRdata,
    input  logic      dcacheStall
);

    logic advance;   // both caches ready

    wordAddr_t pc;
    word_t     ifIdInstr;

    // ID stage
    logic       idRegWrite, idMemRead, idMemWrite, idMemToReg, idAluSrc;
    logic [1:0] idAluClass;
    word_t      idImm, idRData1, idRData2;
    regAddr_t   idRs1, idRs2, idRd;

    logic       idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg, idExAluSrc;
    logic [1:0] idExAluClass;
    logic [2:0] idExFunct3;
    logic       idExFunct7b5;
    word_t      idExRData1, idExRData2, idExImm;
    regAddr_t   idExRs1, idExRs2, idExRd;

    logic       exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg;
    word_t      exMemAlu, exMemStoreData;
    regAddr_t   exMemRd;

    logic       memWbRegWrite, memWbMemToReg;
    word_t      memWbLoadData, memWbAlu;
    regAddr_t   memWbRd;

    fwdSel_t    fwdSelA, fwdSelB;
    logic       loadUseStall;
    word_t      aluResult, storeData;
    word_t      wbData;

    assign advance = !icacheStall && !dcacheStall;

    assign icacheAddr  = pc;
    assign dcacheRen   = exMemMemRead;
    assign dcacheWen   = exMemMemWrite;
    assign dcacheAddr  = exMemAlu[31:2];
    assign dcacheWdata = exMemStoreData;

    assign wbData = memWbMemToReg ? memWbLoadData : memWbAlu;

    // fetch is held on load-use so the same word is fetched again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= '0;
            ifIdInstr <= '0;   // decodes as nop
        end else if (advance && !loadUseStall) begin
            pc        <= pc + 30'd1;
            ifIdInstr <= icacheRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExMemToReg <= 1'b0;
            idExAluSrc   <= 1'b0;
            idExAluClass <= CLS_MEM;
            idExFunct3   <= '0;
            idExFunct7b5 <= 1'b0;
            idExRData1   <= '0;
            idExRData2   <= '0;
            idExImm      <= '0;
            idExRs1      <= '0;
            idExRs2      <= '0;
            idExRd       <= '0;
        end else if (advance) begin
            idExRegWrite <= idRegWrite && !loadUseStall;   // bubble
            idExMemRead  <= idMemRead && !loadUseStall;
            idExMemWrite <= idMemWrite && !loadUseStall;
            idExMemToReg <= idMemToReg && !loadUseStall;
            idExAluSrc   <= idAluSrc && !loadUseStall;
            idExAluClass <= loadUseStall ? CLS_MEM : idAluClass;
            idExFunct3   <= ifIdInstr[14:12];
            idExFunct7b5 <= ifIdInstr[30];
            idExRData1   <= idRData1;
            idExRData2   <= idRData2;
            idExImm      <= idImm;
            idExRs1      <= idRs1;
            idExRs2      <= idRs2;
            idExRd       <= idRd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exMemRegWrite  <= 1'b0;
            exMemMemRead   <= 1'b0;
            exMemMemWrite  <= 1'b0;
            exMemMemToReg  <= 1'b0;
            exMemAlu       <= '0;
            exMemStoreData <= '0;
            exMemRd        <= '0;
            memWbRegWrite  <= 1'b0;
            memWbMemToReg  <= 1'b0;
            memWbLoadData  <= '0;
            memWbAlu       <= '0;
            memWbRd        <= '0;
        end else if (advance) begin
            exMemRegWrite  <= idExRegWrite;
            exMemMemRead   <= idExMemRead;
            exMemMemWrite  <= idExMemWrite;
            exMemMemToReg  <= idExMemToReg;
            exMemAlu       <= aluResult;
            exMemStoreData <= storeData;
            exMemRd        <= idExRd;
            memWbRegWrite  <= exMemRegWrite;
            memWbMemToReg  <= exMemMemToReg;
            memWbLoadData  <= dcacheRdata;
            memWbAlu       <= exMemAlu;
            memWbRd        <= exMemRd;
        end
    end

    instrDecoder decoder (
        .instr    (ifIdInstr),
        .regWrite (idRegWrite),
        .memRead  (idMemRead),
        .memWrite (idMemWrite),
        .memToReg (idMemToReg),
        .aluSrc   (idAluSrc),
        .aluClass (idAluClass),
        .imm      (idImm),
        .rs1      (idRs1),
        .rs2      (idRs2),
        .rd       (idRd)
    );

    // a frozen MEM/WB harmlessly rewrites the same value
    regFile rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (idRs1),
        .rs2    (idRs2),
        .rData1 (idRData1),
        .rData2 (idRData2),
        .we     (memWbRegWrite),
        .rd     (memWbRd),
        .wData  (wbData)
    );

    hazardUnit hazard (
        .idRs1        (idRs1),
        .idRs2        (idRs2),
        .exRs1        (idExRs1),
        .exRs2        (idExRs2),
        .exRd         (idExRd),
        .memRd        (exMemRd),
        .wbRd         (memWbRd),
        .exMemRead    (idExMemRead),
        .memRegWrite  (exMemRegWrite),
        .wbRegWrite   (memWbRegWrite),
        .fwdSelA      (fwdSelA),
        .fwdSelB      (fwdSelB),
        .loadUseStall (loadUseStall)
    );

    execUnit exec (
        .aluClass  (idExAluClass),
        .funct3    (idExFunct3),
        .funct7b5  (idExFunct7b5),
        .aluSrc    (idExAluSrc),
        .rData1    (idExRData1),
        .rData2    (idExRData2),
        .imm       (idExImm),
        .memResult (exMemAlu),
        .wbResult  (wbData),
        .fwdSelA   (fwdSelA),
        .fwdSelB   (fwdSelB),
        .aluResult (aluResult),
        .storeData (storeData)
    );

endmodule

// ==== tb/riscvPipeline_props.sv ====
module riscvPipeline_props import pipePkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      dcacheRen,
    input logic      dcacheWen,
    input wordAddr_t dcacheAddr,
    input word_t     dcacheWdata,
    input logic      dcacheStall
);

    timeunit 1ns;
    timeprecision 100ps;

    noBothStrobes: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen))
        else $error("dcache read and write strobes high together");

    // frozen pipeline keeps the request steady
    holdOnStall: assert property (@(posedge clk) disable iff (!rst_n)
        dcacheStall |=> $stable({dcacheRen, dcacheWen, dcacheAddr, dcacheWdata}))
        else $error("dcache outputs changed under dcacheStall");

    knownStrobes: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({dcacheRen, dcacheWen}))
        else $error("dcache strobe unknown");

    knownAddr: assert property (@(posedge clk) disable iff (!rst_n)
        (dcacheRen || dcacheWen) |-> !$isunknown(dcacheAddr))
        else $error("dcache address unknown during an access");

endmodule

bind riscvPipeline riscvPipeline_props props (
    .clk         (clk),
    .rst_n       (rst_n),
    .dcacheRen   (dcacheRen),
    .dcacheWen   (dcacheWen),
    .dcacheAddr  (dcacheAddr),
    .dcacheWdata (dcacheWdata),
    .dcacheStall (dcacheStall)
);

// ==== tb/riscvPipelineTb.sv ====
module riscvPipelineTb import pipePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD      = 4;
    localparam int    RESET_CYCLES    = 16;
    localparam int    RAND_LEN        = 200;
    localparam int    PROG_LEN        = RAND_LEN + 31;   // plus register dump
    localparam int    WATCHDOG_CYCLES = RESET_CYCLES + 20 * PROG_LEN;
    localparam word_t NOP             = 32'h0000_0013;   // addi x0, x0, 0

    logic      clk         = 1'b0;
    logic      rst_n       = 1'b0;
    logic      icacheStall = 1'b0;
    logic      dcacheStall = 1'b0;
    wordAddr_t icacheAddr, dcacheAddr;
    word_t     icacheRdata, dcacheRdata, dcacheWdata;
    logic      dcacheRen, dcacheWen;

    word_t     imem [256];
    word_t     dmem [64];
    word_t     dataInit [64];
    word_t     modelRegs [NUM_REGS];   // ISA state
    word_t     modelMem [64];
    wordAddr_t loadQ [$];
    wordAddr_t storeAddrQ [$];
    word_t     storeDataQ [$];
    integer    seed       = 7;
    int        storeCount = 0;
    int        numStores  = 0;
    wordAddr_t lastPc     = '0;
    logic      firstCycle = 1'b1;

    riscvPipeline i_dut (.*);

    assign icacheRdata = (icacheAddr < 30'd256) ? imem[icacheAddr[7:0]] : NOP;
    assign dcacheRdata = dmem[dcacheAddr[5:0]];

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // RV32I semantics with alt selecting sub and sra
    function automatic word_t aluRef(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t emitStore(input regAddr_t src, input logic [5:0] slot);
        storeAddrQ.push_back(wordAddr_t'(slot));
        storeDataQ.push_back(modelRegs[src]);
        modelMem[slot] = modelRegs[src];
        return {4'b0, slot[5:3], src, 5'd0, 3'b010, slot[2:0], 2'b00, 7'b0100011};
    endfunction

    task automatic buildProgram();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [5:0]  slot;
        regAddr_t    rd, rs1, rs2, prevRd;
        int          kind;

        prevRd = '0;
        for (int i = 0; i < 256; i++)
            imem[i] = NOP;
        for (int i = 0; i < NUM_REGS; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < 64; i++) begin
            dataInit[i] = $random(seed);
            modelMem[i] = dataInit[i];
        end
        for (int i = 0; i < RAND_LEN; i++) begin
            kind = rnd(8);
            f3   = 3'(rnd(7));
            f3   = (f3 >= 3'd3) ? f3 + 3'd1 : f3;   // no sltu
            rd   = regAddr_t'(1 + rnd(31));
            rs1  = (prevRd != '0 && rnd(3) == 0) ? prevRd : regAddr_t'(1 + rnd(31));
            rs2  = regAddr_t'(1 + rnd(31));
            slot = 6'(rnd(64));
            imm  = 12'(rnd(4096));
            prevRd = rd;   // dependent next instruction exercises forwarding
            if (kind < 3) begin
                alt = (f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 1;
                imem[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
                modelRegs[rd] = aluRef(f3, alt, modelRegs[rs1], modelRegs[rs2]);
            end else if (kind < 6) begin
                alt = (f3 == 3'b101) && rnd(2) == 1;
                if (f3 == 3'b001 || f3 == 3'b101)
                    imm = {1'b0, alt, 5'b0, imm[4:0]};   // shamt form
                imem[i] = {imm, rs1, f3, rd, 7'b0010011};
                modelRegs[rd] = aluRef(f3, alt, modelRegs[rs1], {{20{imm[11]}}, imm});
            end else if (kind == 6) begin
                imem[i] = {4'b0, slot, 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
                loadQ.push_back(wordAddr_t'(slot));
                modelRegs[rd] = modelMem[slot];
            end else begin
                imem[i] = emitStore(rs2, slot);
                prevRd  = '0;
            end
        end
        // each register to its own slot
        for (int r = 1; r < NUM_REGS; r++)
            imem[RAND_LEN + r - 1] = emitStore(regAddr_t'(r), 6'(r));
        numStores = storeAddrQ.size();
    endtask

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkAddr(input string name, input wordAddr_t exp, input wordAddr_t act);
        if (exp !== act)
            stopWithFailure($sformatf("** Error at %0t ns: %s expected %h, got %h",
                                      $time, name, exp, act));
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (exp !== act)
            stopWithFailure($sformatf("** Error at %0t ns: %s expected %h, got %h",
                                      $time, name, exp, act));
    endtask

    task automatic finishRun();
        if (loadQ.size() != 0 || storeCount != numStores) begin
            stopWithFailure($sformatf("program ended with %0d loads unseen, %0d of %0d stores",
                                      loadQ.size(), storeCount, numStores));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    endtask

    task automatic checkLoad();
        if (loadQ.size() == 0)
            stopWithFailure("a load appeared that the program does not contain");
        else
            checkAddr("dcacheAddr", loadQ.pop_front(), dcacheAddr);
    endtask

    task automatic checkStore();
        if (storeAddrQ.size() == 0) begin
            stopWithFailure("a store appeared after the last expected store");
        end else begin
            checkAddr("dcacheAddr", storeAddrQ.pop_front(), dcacheAddr);
            checkWord("dcacheWdata", storeDataQ.pop_front(), dcacheWdata);
            storeCount++;
        end
    endtask

    initial begin
        buildProgram();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            icacheStall <= (rnd(4) == 0);
            dcacheStall <= (rnd(4) == 0);
        end
    end

    always @(posedge clk) begin
        if (!rst_n)
            dmem <= dataInit;
        else if (dcacheWen && !dcacheStall)
            dmem[dcacheAddr[5:0]] <= dcacheWdata;
    end

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!rst_n || firstCycle) begin
            if (dcacheRen || dcacheWen)
                stopWithFailure("dcache strobe high during or right after reset");
            checkAddr("icacheAddr", '0, icacheAddr);
            lastPc     = '0;
            firstCycle = !rst_n;
        end else begin
            if (icacheAddr != lastPc)
                checkAddr("icacheAddr", lastPc + 30'd1, icacheAddr);
            lastPc = icacheAddr;
            // an access leaves EX/MEM only when neither cache stalls
            if (!icacheStall && !dcacheStall && dcacheRen)
                checkLoad();
            if (!icacheStall && !dcacheStall && dcacheWen)
                checkStore();
            // fetch this far past the last store means it has left EX/MEM
            if (icacheAddr == wordAddr_t'(PROG_LEN + 4))
                finishRun();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stopWithFailure("watchdog fired, the program did not finish in time");
    end

endmodule

// ==== sim.f ====
source/pipePkg.sv
source/instrDecoder.sv
source/execUnit.sv
source/regFile.sv
source/hazardUnit.sv
source/riscvPipeline.sv
tb/riscvPipeline_props.sv
tb/riscvPipelineTb.sv

// ==== Makefile ====
RTL = source/pipePkg.sv source/instrDecoder.sv source/execUnit.sv \
      source/regFile.sv source/hazardUnit.sv source/riscvPipeline.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module riscvPipeline $(RTL)

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module riscvPipelineTb -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir
